// File: dv/tb_clock_gen.sv
// free-running 100 ns clock, reset high for the first 16 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	localparam int HALF_PERIOD_NS = 50;
	localparam int RESET_CYCLES   = 16;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
	end

	// release on a falling edge, clear of the capturing edge
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

`default_nettype wire

// File: dv/wb_subsystem_tb.sv
// drives the master port on falling edges, samples ack and data on rising edges
// RAM is filled with an address pattern before random reads, so no read sees X
`timescale 1ns/1ps
`default_nettype none

`include "wb_settings.svh"

module wb_subsystem_tb;

	localparam int CLK_PERIOD_NS          = 100;
	localparam int RESET_CYCLES           = 16;
	localparam int ACK_TIMEOUT_CYCLES     = 15;
	localparam int TRANSACTION_BUDGET     = 600;
	localparam int RANDOM_OPS             = 200;
	localparam int RAM_WORDS              = 1 << `WB_RAM_ADR_BITS;
	// worst case for every transaction plus reset, about 0.9 ms
	localparam int WATCHDOG_NS =
		(TRANSACTION_BUDGET * ACK_TIMEOUT_CYCLES + RESET_CYCLES) * CLK_PERIOD_NS;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam wb_pkg::wb_adr_t REGS_BASE = 16'h4000;

	logic            clk;
	logic            reset;
	wb_pkg::wb_adr_t wb_adr;
	wb_pkg::wb_dat_t wb_dat_w;
	logic            wb_we;
	wb_pkg::wb_sel_t wb_sel;
	logic            wb_stb;
	wb_pkg::wb_dat_t wb_dat_r;
	logic            wb_ack;

	// reference model
	wb_pkg::wb_dat_t ram_model [0:RAM_WORDS-1];
	wb_pkg::wb_dat_t regs_model [0:2];
	wb_pkg::wb_dat_t count_model;

	logic [31:0] lfsr_state = 32'd90016;
	int          check_count = 0;
	int          error_count = 0;
	int          timeout_count = 0;

	tb_clock_gen u_clock_gen (
		.clk_o   (clk),
		.reset_o (reset)
	);

	wb_subsystem u_wb_subsystem (
		.clk      (clk),
		.reset    (reset),
		.wb_adr_i (wb_adr),
		.wb_dat_i (wb_dat_w),
		.wb_we_i  (wb_we),
		.wb_sel_i (wb_sel),
		.wb_stb_i (wb_stb),
		.wb_dat_o (wb_dat_r),
		.wb_ack_o (wb_ack)
	);

	// ------------------------------
	// random source and model
	// ------------------------------
	function automatic wb_pkg::wb_dat_t random_bits(input int nbits);
		wb_pkg::wb_dat_t value;
		logic            out_bit;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			out_bit    = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (out_bit) begin
				lfsr_state = lfsr_state ^ LFSR_TAPS;
			end
			value = {value[`WB_DAT_WIDTH-2:0], out_bit};
		end
		return value;
	endfunction

	function automatic wb_pkg::wb_dat_t merge_bytes(input wb_pkg::wb_dat_t old_word,
			input wb_pkg::wb_dat_t new_word, input wb_pkg::wb_sel_t sel);
		wb_pkg::wb_dat_t result;
		result = old_word;
		for (int i = 0; i < `WB_SEL_WIDTH; i++) begin
			if (sel[i]) begin
				result[i*8 +: 8] = new_word[i*8 +: 8];
			end
		end
		return result;
	endfunction

	function automatic wb_pkg::wb_region_e region_of(input wb_pkg::wb_adr_t adr);
		return wb_pkg::wb_region_e'(adr[`WB_ADR_WIDTH-1 -: 2]);
	endfunction

	task automatic model_write(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat,
			input wb_pkg::wb_sel_t sel);
		if (region_of(adr) == wb_pkg::REGION_RAM) begin
			ram_model[adr[`WB_RAM_ADR_BITS-1:0]] =
				merge_bytes(ram_model[adr[`WB_RAM_ADR_BITS-1:0]], dat, sel);
		end else if (region_of(adr) == wb_pkg::REGION_REGS && adr[1:0] != 2'd3) begin
			regs_model[adr[1:0]] = merge_bytes(regs_model[adr[1:0]], dat, sel);
			count_model = count_model + 1;
		end
	endtask

	function automatic wb_pkg::wb_dat_t model_read(input wb_pkg::wb_adr_t adr);
		case (region_of(adr))
			wb_pkg::REGION_RAM:  return ram_model[adr[`WB_RAM_ADR_BITS-1:0]];
			wb_pkg::REGION_REGS: return (adr[1:0] == 2'd3) ? count_model : regs_model[adr[1:0]];
			default:             return `WB_UNMAPPED_DATA;
		endcase
	endfunction

	// ------------------------------
	// bus access
	// ------------------------------
	task automatic bus_access(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat,
			input logic we, input wb_pkg::wb_sel_t sel,
			output wb_pkg::wb_dat_t rdat, output logic ok);
		int waited;
		waited = 0;
		ok     = 1'b0;
		rdat   = '0;
		@(negedge clk);
		wb_adr   = adr;
		wb_dat_w = dat;
		wb_we    = we;
		wb_sel   = sel;
		wb_stb   = 1'b1;
		while (!ok && waited < ACK_TIMEOUT_CYCLES) begin
			@(posedge clk);
			if (wb_ack) begin
				ok   = 1'b1;
				rdat = wb_dat_r;
			end
			waited++;
		end
		if (!ok) begin
			$display("ERROR: no ack within %0d cycles for %s at address %04h",
				ACK_TIMEOUT_CYCLES, we ? "write" : "read", adr);
			timeout_count++;
		end
	endtask

	task automatic idle_cycles(input int n);
		if (n > 0) begin
			@(negedge clk);
			wb_stb = 1'b0;
			wb_we  = 1'b0;
			repeat (n - 1) @(negedge clk);
		end
	endtask

	task automatic write_word(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat,
			input wb_pkg::wb_sel_t sel);
		wb_pkg::wb_dat_t unused;
		logic            ok;
		bus_access(adr, dat, 1'b1, sel, unused, ok);
		if (ok) begin
			model_write(adr, dat, sel);
		end
	endtask

	task automatic check_value(input string name, input wb_pkg::wb_dat_t expected,
			input wb_pkg::wb_dat_t actual);
		check_count++;
		assert (actual === expected)
		else begin
			$display("CHECK FAILED %s: expected %08h, actual %08h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic read_expect(input string name, input wb_pkg::wb_adr_t adr,
			input wb_pkg::wb_dat_t expected);
		wb_pkg::wb_dat_t rdat;
		logic            ok;
		bus_access(adr, '0, 1'b0, '1, rdat, ok);
		if (ok) begin
			check_value(name, expected, rdat);
		end
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	initial begin
		wb_pkg::wb_adr_t adr;
		wb_pkg::wb_dat_t dat;
		wb_pkg::wb_sel_t sel;

		wb_adr      = '0;
		wb_dat_w    = '0;
		wb_we       = 1'b0;
		wb_sel      = '0;
		wb_stb      = 1'b0;
		count_model = '0;
		for (int r = 0; r < 3; r++) begin
			regs_model[r] = '0;
		end
		@(negedge reset);

		for (int r = 0; r < 4; r++) begin
			read_expect("reset_regs", REGS_BASE | wb_pkg::wb_adr_t'(r), 32'h0000_0000);
		end

		// pattern uses the whole word address
		for (int a = 0; a < RAM_WORDS; a++) begin
			adr = wb_pkg::wb_adr_t'(a);
			write_word(adr, {adr ^ 16'hC35A, ~adr}, '1);
		end

		write_word(16'h0012, 32'h1122_3344, 4'b1111);
		read_expect("ram_full", 16'h0012, 32'h1122_3344);
		write_word(16'h0012, 32'hAABB_CCDD, 4'b0101);
		read_expect("ram_merge", 16'h0012, 32'h11BB_33DD);
		write_word(16'h0012, 32'h9900_0000, 4'b1000);
		read_expect("ram_merge", 16'h0012, 32'h99BB_33DD);

		write_word(REGS_BASE | 16'd0, 32'hA1B2_C3D4, 4'b1111);
		write_word(REGS_BASE | 16'd1, 32'h0123_4567, 4'b1111);
		write_word(REGS_BASE | 16'd1, 32'hFFEE_DDCC, 4'b1010);
		write_word(REGS_BASE | 16'd2, 32'h55AA_55AA, 4'b0011);
		read_expect("regs_merge", REGS_BASE | 16'd0, 32'hA1B2_C3D4);
		read_expect("regs_merge", REGS_BASE | 16'd1, 32'hFF23_DD67);
		read_expect("regs_merge", REGS_BASE | 16'd2, 32'h0000_55AA);
		read_expect("regs_count", REGS_BASE | 16'd3, 32'd4);
		write_word(REGS_BASE | 16'd3, 32'hFFFF_FFFF, 4'b1111);
		read_expect("regs_count_ro", REGS_BASE | 16'd3, 32'd4);

		read_expect("unmapped_read", 16'h8000, `WB_UNMAPPED_DATA);
		read_expect("unmapped_read", 16'hC0FF, `WB_UNMAPPED_DATA);
		// low bits alias the RAM word and scratch register used above
		write_word(16'h8012, 32'h0BAD_F00D, 4'b1111);
		write_word(16'hC002, 32'h0BAD_F00D, 4'b1111);
		read_expect("unmapped_write", 16'h0012, 32'h99BB_33DD);
		read_expect("unmapped_write", REGS_BASE | 16'd2, 32'h0000_55AA);
		read_expect("unmapped_write", REGS_BASE | 16'd3, 32'd4);

		// mostly RAM, one in eight to the registers
		for (int n = 0; n < RANDOM_OPS; n++) begin
			if (random_bits(3) == 0) begin
				adr = REGS_BASE | wb_pkg::wb_adr_t'(random_bits(2));
			end else begin
				adr = wb_pkg::wb_adr_t'(random_bits(`WB_RAM_ADR_BITS));
			end
			if (random_bits(1) == 1) begin
				dat = random_bits(`WB_DAT_WIDTH);
				sel = wb_pkg::wb_sel_t'(random_bits(`WB_SEL_WIDTH));
				write_word(adr, dat, sel);
			end else begin
				read_expect("random", adr, model_read(adr));
			end
			idle_cycles(int'(random_bits(2)));
		end
		idle_cycles(4);

		$display("summary: %0d checks, %0d mismatches, %0d timeouts",
			check_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired after %0d ns, the run stalled", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/wb_decoder.sv
// routes the strobe by the top two address bits, muxes ack and data back
// unmapped accesses ack after one cycle, writes there are dropped
`timescale 1ns/1ps
`default_nettype none

`include "wb_settings.svh"

module wb_decoder (
	input  wire                  clk,
	input  wire                  reset,
	input  wire wb_pkg::wb_adr_t wb_adr_i,
	input  wire wb_pkg::wb_dat_t wb_dat_i,
	input  wire                  wb_we_i,
	input  wire wb_pkg::wb_sel_t wb_sel_i,
	input  wire                  wb_stb_i,
	output wb_pkg::wb_dat_t      wb_dat_o,
	output logic                 wb_ack_o,
	output logic                 ram_stb_o,
	output logic                 regs_stb_o,
	input  wire wb_pkg::wb_dat_t ram_dat_i,
	input  wire                  ram_ack_i,
	input  wire wb_pkg::wb_dat_t regs_dat_i,
	input  wire                  regs_ack_i
);

	wb_pkg::wb_region_e region;
	logic               unm_stb;
	logic               unm_ack;

	assign region     = wb_pkg::wb_region_e'(wb_adr_i[`WB_ADR_WIDTH-1 -: 2]);
	assign ram_stb_o  = wb_stb_i & (region == wb_pkg::REGION_RAM);
	assign regs_stb_o = wb_stb_i & (region == wb_pkg::REGION_REGS);
	assign unm_stb    = wb_stb_i & (region == wb_pkg::REGION_UNMAPPED_A
		| region == wb_pkg::REGION_UNMAPPED_B);

	// default responder, one ack per strobe
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			unm_ack <= 1'b0;
		end else begin
			unm_ack <= unm_stb & ~unm_ack;
		end
	end

	always_comb begin
		case (region)
			wb_pkg::REGION_RAM: begin
				wb_dat_o = ram_dat_i;
				wb_ack_o = ram_ack_i;
			end
			wb_pkg::REGION_REGS: begin
				wb_dat_o = regs_dat_i;
				wb_ack_o = regs_ack_i;
			end
			default: begin
				wb_dat_o = `WB_UNMAPPED_DATA;
				wb_ack_o = unm_ack;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/wb_pkg.sv
// bus types shared by the RTL and the testbench model
// region is taken from the top two word-address bits
`default_nettype none

`include "wb_settings.svh"

package wb_pkg;

	typedef logic [`WB_ADR_WIDTH-1:0] wb_adr_t;
	typedef logic [`WB_DAT_WIDTH-1:0] wb_dat_t;
	typedef logic [`WB_SEL_WIDTH-1:0] wb_sel_t;

	// address map, top two bits
	typedef enum logic [1:0] {
		REGION_RAM        = 2'd0,
		REGION_REGS       = 2'd1,
		REGION_UNMAPPED_A = 2'd2,
		REGION_UNMAPPED_B = 2'd3
	} wb_region_e;

endpackage

`default_nettype wire

// File: hdl/wb_ram_slave.sv
// 256-word RAM, upper address bits are ignored so the region aliases
// read data and ack are registered, one ack per strobe
`timescale 1ns/1ps
`default_nettype none

`include "wb_settings.svh"

module wb_ram_slave (
	input  wire                  clk,
	input  wire                  reset,
	input  wire wb_pkg::wb_adr_t adr_i,
	input  wire wb_pkg::wb_dat_t dat_i,
	input  wire                  we_i,
	input  wire wb_pkg::wb_sel_t sel_i,
	input  wire                  stb_i,
	output wb_pkg::wb_dat_t      dat_o,
	output logic                 ack_o
);

	localparam int DEPTH = 1 << `WB_RAM_ADR_BITS;

	wb_pkg::wb_dat_t              mem [0:DEPTH-1];
	logic [`WB_RAM_ADR_BITS-1:0]  word_adr;
	logic                         access;

	assign word_adr = adr_i[`WB_RAM_ADR_BITS-1:0];
	// held strobe is ignored during its own ack cycle
	assign access   = stb_i & ~ack_o;

	// ------------------------------
	// storage and read port
	// ------------------------------
	always_ff @(posedge clk) begin
		if (access & we_i) begin
			for (int i = 0; i < `WB_SEL_WIDTH; i++) begin
				if (sel_i[i]) begin
					mem[word_adr][i*8 +: 8] <= dat_i[i*8 +: 8];
				end
			end
		end

		if (access & ~we_i) begin
			dat_o <= mem[word_adr];
		end
	end

	// ------------------------------
	// ack
	// ------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= access;
		end
	end

endmodule

`default_nettype wire

// File: hdl/wb_scratch_regs.sv
// offsets 0..2 scratch, offset 3 read-only write counter that wraps
// only the low two address bits decode, so the block aliases
`timescale 1ns/1ps
`default_nettype none

`include "wb_settings.svh"

module wb_scratch_regs (
	input  wire                  clk,
	input  wire                  reset,
	input  wire wb_pkg::wb_adr_t adr_i,
	input  wire wb_pkg::wb_dat_t dat_i,
	input  wire                  we_i,
	input  wire wb_pkg::wb_sel_t sel_i,
	input  wire                  stb_i,
	output wb_pkg::wb_dat_t      dat_o,
	output logic                 ack_o
);

	wb_pkg::wb_dat_t scratch [0:2];
	wb_pkg::wb_dat_t write_count;
	logic [1:0]      offset;
	logic            access;
	logic            scratch_wr;

	assign offset     = adr_i[1:0];
	assign access     = stb_i & ~ack_o;
	assign scratch_wr = access & we_i & (offset != 2'd3);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int r = 0; r < 3; r++) begin
				scratch[r] <= '0;
			end
			write_count <= '0;
			ack_o       <= 1'b0;
		end else begin
			if (scratch_wr) begin
				for (int i = 0; i < `WB_SEL_WIDTH; i++) begin
					if (sel_i[i]) begin
						scratch[offset][i*8 +: 8] <= dat_i[i*8 +: 8];
					end
				end
				write_count <= write_count + 1'b1;
			end
			ack_o <= access;
		end
	end

	// read mux, counter at offset 3
	always_ff @(posedge clk) begin
		if (access & ~we_i) begin
			dat_o <= (offset == 2'd3) ? write_count : scratch[offset];
		end
	end

endmodule

`default_nettype wire

// File: hdl/wb_settings.svh
// bus widths, RAM depth and the unmapped read value
// WB_SEL_WIDTH needs a data width that is a multiple of 8
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// word address and data widths
`define WB_ADR_WIDTH     16
`define WB_DAT_WIDTH     32
`define WB_SEL_WIDTH     (`WB_DAT_WIDTH / 8)

// RAM decodes only the low address bits, 256 words
`define WB_RAM_ADR_BITS  8

// returned on reads outside the RAM and register regions
`define WB_UNMAPPED_DATA 32'hDEADBEEF

`endif

// File: hdl/wb_subsystem.sv
// master port -> bridge -> decoder -> RAM, scratch registers
// plain strobe/ack master, holds its request until ack
`timescale 1ns/1ps
`default_nettype none

module wb_subsystem (
	input  wire                  clk,
	input  wire                  reset,
	input  wire wb_pkg::wb_adr_t wb_adr_i,
	input  wire wb_pkg::wb_dat_t wb_dat_i,
	input  wire                  wb_we_i,
	input  wire wb_pkg::wb_sel_t wb_sel_i,
	input  wire                  wb_stb_i,
	output wb_pkg::wb_dat_t      wb_dat_o,
	output logic                 wb_ack_o
);

	// bridge output bus
	wb_pkg::wb_adr_t bus_adr;
	wb_pkg::wb_dat_t bus_wdat;
	logic            bus_we;
	wb_pkg::wb_sel_t bus_sel;
	logic            bus_stb;
	wb_pkg::wb_dat_t bus_rdat;
	logic            bus_ack;

	// per-target strobe and return
	logic            ram_stb;
	wb_pkg::wb_dat_t ram_dat;
	logic            ram_ack;
	logic            regs_stb;
	wb_pkg::wb_dat_t regs_dat;
	logic            regs_ack;

	wishbone_bridge u_bridge (
		.clk          (clk),
		.reset        (reset),
		.wb_in_adr_i  (wb_adr_i),
		.wb_in_dat_i  (wb_dat_i),
		.wb_in_we_i   (wb_we_i),
		.wb_in_sel_i  (wb_sel_i),
		.wb_in_stb_i  (wb_stb_i),
		.wb_in_dat_o  (wb_dat_o),
		.wb_in_ack_o  (wb_ack_o),
		.wb_out_adr_o (bus_adr),
		.wb_out_dat_o (bus_wdat),
		.wb_out_we_o  (bus_we),
		.wb_out_sel_o (bus_sel),
		.wb_out_stb_o (bus_stb),
		.wb_out_dat_i (bus_rdat),
		.wb_out_ack_i (bus_ack)
	);

	wb_decoder u_decoder (
		.clk        (clk),
		.reset      (reset),
		.wb_adr_i   (bus_adr),
		.wb_dat_i   (bus_wdat),
		.wb_we_i    (bus_we),
		.wb_sel_i   (bus_sel),
		.wb_stb_i   (bus_stb),
		.wb_dat_o   (bus_rdat),
		.wb_ack_o   (bus_ack),
		.ram_stb_o  (ram_stb),
		.regs_stb_o (regs_stb),
		.ram_dat_i  (ram_dat),
		.ram_ack_i  (ram_ack),
		.regs_dat_i (regs_dat),
		.regs_ack_i (regs_ack)
	);

	wb_ram_slave u_ram (
		.clk   (clk),
		.reset (reset),
		.adr_i (bus_adr),
		.dat_i (bus_wdat),
		.we_i  (bus_we),
		.sel_i (bus_sel),
		.stb_i (ram_stb),
		.dat_o (ram_dat),
		.ack_o (ram_ack)
	);

	wb_scratch_regs u_regs (
		.clk   (clk),
		.reset (reset),
		.adr_i (bus_adr),
		.dat_i (bus_wdat),
		.we_i  (bus_we),
		.sel_i (bus_sel),
		.stb_i (regs_stb),
		.dat_o (regs_dat),
		.ack_o (regs_ack)
	);

endmodule

`default_nettype wire

// File: hdl/wishbone_bridge.sv
// register slice with a one-entry posted-write buffer
// write ack is combinational and depends on we, so the master ignores ack while stb is low
`timescale 1ns/1ps
`default_nettype none

module wishbone_bridge (
	input  wire              clk,
	input  wire              reset,

	// master side
	input  wire wb_pkg::wb_adr_t wb_in_adr_i,
	input  wire wb_pkg::wb_dat_t wb_in_dat_i,
	input  wire              wb_in_we_i,
	input  wire wb_pkg::wb_sel_t wb_in_sel_i,
	input  wire              wb_in_stb_i,
	output wb_pkg::wb_dat_t  wb_in_dat_o,
	output logic             wb_in_ack_o,

	// slave side
	output wb_pkg::wb_adr_t  wb_out_adr_o,
	output wb_pkg::wb_dat_t  wb_out_dat_o,
	output logic             wb_out_we_o,
	output wb_pkg::wb_sel_t  wb_out_sel_o,
	output logic             wb_out_stb_o,
	input  wire wb_pkg::wb_dat_t wb_out_dat_i,
	input  wire              wb_out_ack_i
);

	logic out_free;
	logic wr_accept;
	logic rd_issue;
	logic out_read;
	logic rd_busy;
	logic rd_ack;

	// posted write parked while the output stage stalls
	logic            buf_vld;
	wb_pkg::wb_adr_t buf_adr;
	wb_pkg::wb_dat_t buf_dat;
	wb_pkg::wb_sel_t buf_sel;

	// ------------------------------
	// accept conditions
	// ------------------------------
	assign out_free  = ~wb_out_stb_o | wb_out_ack_i;
	assign wr_accept = wb_in_stb_i & wb_in_we_i & ~buf_vld;
	// no posted write may still be pending when a read goes out
	assign rd_issue  = wb_in_stb_i & ~wb_in_we_i & ~rd_busy & ~buf_vld & out_free;

	assign wb_in_ack_o = wb_in_we_i ? ~buf_vld : rd_ack;

	// ------------------------------
	// control state
	// ------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wb_out_stb_o <= 1'b0;
			wb_out_sel_o <= '0;
			out_read     <= 1'b0;
			buf_vld      <= 1'b0;
			rd_busy      <= 1'b0;
			rd_ack       <= 1'b0;
		end else begin
			if (out_free) begin
				if (buf_vld) begin
					wb_out_stb_o <= 1'b1;
					wb_out_sel_o <= buf_sel;
					out_read     <= 1'b0;
				end else if (wr_accept | rd_issue) begin
					wb_out_stb_o <= 1'b1;
					wb_out_sel_o <= wb_in_sel_i;
					out_read     <= rd_issue;
				end else begin
					wb_out_stb_o <= 1'b0;
					out_read     <= 1'b0;
				end
			end

			// buffer drains whenever the output stage frees up
			if (out_free) begin
				buf_vld <= 1'b0;
			end else if (wr_accept) begin
				buf_vld <= 1'b1;
			end

			// read stays outstanding until its ack reaches the master
			if (rd_issue) begin
				rd_busy <= 1'b1;
			end else if (rd_ack) begin
				rd_busy <= 1'b0;
			end

			rd_ack <= wb_out_stb_o & out_read & wb_out_ack_i;
		end
	end

	// ------------------------------
	// payload
	// ------------------------------
	always_ff @(posedge clk) begin
		if (out_free) begin
			if (buf_vld) begin
				wb_out_adr_o <= buf_adr;
				wb_out_dat_o <= buf_dat;
				wb_out_we_o  <= 1'b1;
			end else begin
				wb_out_adr_o <= wb_in_adr_i;
				wb_out_dat_o <= wb_in_dat_i;
				wb_out_we_o  <= wb_in_we_i;
			end
		end

		if (~out_free & wr_accept) begin
			buf_adr <= wb_in_adr_i;
			buf_dat <= wb_in_dat_i;
			buf_sel <= wb_in_sel_i;
		end

		// capture read data with the downstream ack
		if (wb_out_stb_o & out_read & wb_out_ack_i) begin
			wb_in_dat_o <= wb_out_dat_i;
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the wb_subsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module wb_subsystem_tb -o wb_subsystem_sim; then
	echo "verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/wb_subsystem_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "PASS: all tests"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sim.f
+incdir+hdl
hdl/wb_pkg.sv
hdl/wishbone_bridge.sv
hdl/wb_decoder.sv
hdl/wb_ram_slave.sv
hdl/wb_scratch_regs.sv
hdl/wb_subsystem.sv
dv/tb_clock_gen.sv
dv/wb_subsystem_tb.sv
